//--- soc_bus.f
verilog/soc_bus_pkg.sv
verilog/data_ram.sv
verilog/bytes_conv.sv
verilog/gpio_regs.sv
verilog/ticker.sv
verilog/dbus.sv
verilog/soc_bus_top.sv
tests/tb_clock.sv
tests/soc_bus_tb.sv

//--- Makefile
# Verilator build and run for the soc_bus data-bus subsystem.

VERILATOR  ?= verilator
TOP        ?= soc_bus_tb
RTL_TOP    ?= soc_bus_top
FILELIST   ?= soc_bus.f
PATTERNS   ?= tests/soc_bus_patterns.txt
BUILD_DIR  ?= obj_dir
TIMESCALE  ?= 1ns/1ps
VFLAGS     ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall

SOURCES  = $(shell grep '\.s\?v$$' $(FILELIST))
RTL_SRCS = $(shell grep '^verilog/' $(FILELIST))
SIM_BIN  = $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN) $(PATTERNS)
	./$(SIM_BIN)

lint:
	$(VERILATOR) $(LINT_FLAGS) --timescale $(TIMESCALE) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR)

//--- tests/soc_bus_patterns.txt
# op address byteenable wrdata expected
# op is R or W, all other fields hex. expected is checked on reads only.
# RAM full-word writes and read-back
W 00000000 f 11223344 00000000
W 00000010 f cafef00d 00000000
W 000003fc f 89abcdef 00000000
R 00000000 f 00000000 11223344
R 00000010 f 00000000 cafef00d
R 000003fc f 00000000 89abcdef
# RAM partial writes over a known word
W 00000020 f a1b2c3d4 00000000
W 00000020 1 000000ee 00000000
R 00000020 f 00000000 a1b2c3ee
W 00000020 4 00550000 00000000
R 00000020 f 00000000 a155c3ee
W 00000020 c 12340000 00000000
R 00000020 f 00000000 1234c3ee
W 00000020 3 0000beef 00000000
R 00000020 f 00000000 1234beef
# GPIO output register with byte enables
W b0000000 2 0000ab00 00000000
R b0000000 f 00000000 0000ab00
W b0000000 9 7fffff5a 00000000
R b0000000 f 00000000 7f00ab5a
# unmapped reads and writes
R 40000000 f 00000000 00000000
R b0000700 f 00000000 00000000
W 00000040 f 5a5a0001 00000000
W 30000040 f ffffffff 00000000
W b0000740 f ffffffff 00000000
R 00000040 f 00000000 5a5a0001

//--- tests/soc_bus_tb.sv
`timescale 1ns/1ps

module soc_bus_tb import soc_bus_pkg::*; ();

    localparam string PATTERN_FILE = "tests/soc_bus_patterns.txt";
    localparam int STALL_LIMIT = 8;
    localparam int IRQ_LIMIT = 200;
    localparam int RESET_LIMIT = 64;
    localparam int RANDOM_WORDS = 32;
    localparam int RANDOM_BASE = 96;
    localparam int TICK_TARGET = 40;

    logic clk;
    logic rst_n;
    logic [BUS_WIDTH-1:0] bus_address;
    logic [BE_WIDTH-1:0] bus_byteenable;
    logic bus_read;
    logic bus_write;
    logic [BUS_WIDTH-1:0] bus_wrdata;
    logic [BUS_WIDTH-1:0] bus_rddata;
    logic bus_stall;
    logic [BUS_WIDTH-1:0] gpio_in;
    logic [BUS_WIDTH-1:0] gpio_out;
    logic tick_irq;
    logic [BUS_WIDTH-1:0] shadow [RANDOM_WORDS];

    tb_clock clock_i (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    soc_bus_top dut_i (
        .clk              (clk),
        .rst_n_i          (rst_n),
        .bus_address_i    (bus_address),
        .bus_byteenable_i (bus_byteenable),
        .bus_read_i       (bus_read),
        .bus_write_i      (bus_write),
        .bus_wrdata_i     (bus_wrdata),
        .bus_rddata_o     (bus_rddata),
        .bus_stall_o      (bus_stall),
        .gpio_in_i        (gpio_in),
        .gpio_out_o       (gpio_out),
        .tick_irq_o       (tick_irq)
    );

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [BUS_WIDTH-1:0] expected,
                              input logic [BUS_WIDTH-1:0] actual);
        if (actual !== expected) begin
            report_failure($sformatf("ERROR %s: expected %08h, actual %08h",
                                     name, expected, actual));
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            report_failure($sformatf("ERROR %s: expected %b, actual %b", name, expected, actual));
        end
    endtask

    function automatic logic [BUS_WIDTH-1:0] lcg_next(input logic [BUS_WIDTH-1:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [BUS_WIDTH-1:0] ram_address(input logic [RAM_AW-1:0] word);
        bus_addr_t a;
        a = '0;
        a.ram.region = REGION_RAM;
        a.ram.word = word;
        return a;
    endfunction

    function automatic logic [BUS_WIDTH-1:0] io_address(input logic [7:0] dev,
                                                        input logic [REG_AW-1:0] regnum);
        bus_addr_t a;
        a = '0;
        a.io.region = REGION_IO;
        a.io.dev = dev;
        a.io.regnum = regnum;
        return a;
    endfunction

    // a RAM read stalls once and a partial RAM write twice. Nothing else stalls.
    function automatic int expected_stalls(input logic is_write,
                                           input logic [BUS_WIDTH-1:0] address,
                                           input logic [BE_WIDTH-1:0] be);
        bus_addr_t a;
        a = address;
        if (a.ram.region != REGION_RAM) return 0;
        if (!is_write) return 1;
        if (be == '1) return 0;
        return 2;
    endfunction

    task automatic bus_access(input string name, input logic is_write,
                              input logic [BUS_WIDTH-1:0] address,
                              input logic [BE_WIDTH-1:0] be,
                              input logic [BUS_WIDTH-1:0] wrdata,
                              output logic [BUS_WIDTH-1:0] rddata);
        int stalls;
        @(posedge clk);
        bus_address <= address;
        bus_byteenable <= be;
        bus_wrdata <= wrdata;
        bus_read <= !is_write;
        bus_write <= is_write;
        stalls = 0;
        @(negedge clk);
        while (bus_stall) begin
            stalls++;
            if (stalls > STALL_LIMIT) begin
                report_failure($sformatf("%s: stall stayed high for more than %0d cycles",
                                         name, STALL_LIMIT));
            end
            @(negedge clk);
        end
        rddata = bus_rddata;
        check_word({name, " stall cycles"},
                   BUS_WIDTH'(expected_stalls(is_write, address, be)), BUS_WIDTH'(stalls));
        @(posedge clk);
        bus_read <= 1'b0;
        bus_write <= 1'b0;
    endtask

    task automatic run_patterns();
        int fd;
        int n;
        int count;
        logic [7:0] op;
        logic [BUS_WIDTH-1:0] address;
        logic [BE_WIDTH-1:0] be;
        logic [BUS_WIDTH-1:0] wrdata;
        logic [BUS_WIDTH-1:0] expected;
        logic [BUS_WIDTH-1:0] rddata;
        logic [8*128-1:0] rest;
        logic done;
        string name;
        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) report_failure("could not open the pattern file");
        count = 0;
        done = 1'b0;
        while (!done) begin
            n = $fscanf(fd, "%s", op);
            if (n != 1) begin
                done = 1'b1;
            end else if (op == "R" || op == "W") begin
                n = $fscanf(fd, "%h %h %h %h", address, be, wrdata, expected);
                if (n != 4) report_failure("a pattern line has fewer than five fields");
                count++;
                name = $sformatf("pattern %0d %c %08h", count, op, address);
                bus_access(name, op == "W", address, be, wrdata, rddata);
                if (op == "R") begin
                    check_word(name, expected, rddata);
                    // the output register drives the pins directly.
                    if (address == io_address(DEV_GPIO, GPIO_OUT)) begin
                        @(negedge clk);
                        check_word({name, " pins"}, expected, gpio_out);
                    end
                end
            end else begin
                n = $fgets(rest, fd);
            end
        end
        $fclose(fd);
        if (count == 0) report_failure("the pattern file held no transactions");
    endtask

    task automatic random_ram_test();
        logic [BUS_WIDTH-1:0] seed;
        logic [BUS_WIDTH-1:0] rddata;
        seed = 32'hf535;
        for (int i = 0; i < RANDOM_WORDS; i++) begin
            seed = lcg_next(seed);
            shadow[i] = seed;
            bus_access($sformatf("random write %0d", i), 1'b1,
                       ram_address(RAM_AW'(RANDOM_BASE + i)), '1, seed, rddata);
        end
        for (int i = 0; i < RANDOM_WORDS; i++) begin
            bus_access($sformatf("random read %0d", i), 1'b0,
                       ram_address(RAM_AW'(RANDOM_BASE + i)), '1, '0, rddata);
            check_word($sformatf("random read %0d", i), shadow[i], rddata);
        end
    endtask

    task automatic gpio_input_test();
        logic [BUS_WIDTH-1:0] rddata;
        @(posedge clk);
        gpio_in <= 32'h5ac3_0f96;
        // longer than the two-flop synchronizer.
        repeat (4) @(posedge clk);
        bus_access("gpio input read", 1'b0, io_address(DEV_GPIO, GPIO_IN), '1, '0, rddata);
        check_word("gpio input read", 32'h5ac3_0f96, rddata);
    endtask

    task automatic ticker_test();
        logic [BUS_WIDTH-1:0] rddata;
        int cycles;
        bus_access("ticker count load", 1'b1, io_address(DEV_TICKER, TICK_COUNT),
                   '1, '0, rddata);
        bus_access("ticker compare write", 1'b1, io_address(DEV_TICKER, TICK_COMPARE),
                   '1, BUS_WIDTH'(TICK_TARGET), rddata);
        cycles = 0;
        @(negedge clk);
        while (!tick_irq) begin
            cycles++;
            if (cycles > IRQ_LIMIT) report_failure("the tick interrupt never went high");
            @(negedge clk);
        end
        bus_access("ticker count read", 1'b0, io_address(DEV_TICKER, TICK_COUNT),
                   '1, '0, rddata);
        if (rddata < BUS_WIDTH'(TICK_TARGET)) begin
            report_failure($sformatf("ERROR ticker count read: expected >= %0d, actual %0d",
                                     TICK_TARGET, rddata));
        end
        bus_access("ticker status read", 1'b0, io_address(DEV_TICKER, TICK_STATUS),
                   '1, '0, rddata);
        check_word("ticker status read", 32'd1, rddata);
        bus_access("ticker status clear", 1'b1, io_address(DEV_TICKER, TICK_STATUS),
                   '1, 32'd1, rddata);
        @(negedge clk);
        check_bit("ticker irq after clear", 1'b0, tick_irq);
    endtask

    initial begin
        int cycles;
        bus_address <= '0;
        bus_byteenable <= '0;
        bus_read <= 1'b0;
        bus_write <= 1'b0;
        bus_wrdata <= '0;
        gpio_in <= '0;
        cycles = 0;
        @(negedge clk);
        while (!rst_n) begin
            cycles++;
            if (cycles > RESET_LIMIT) report_failure("reset was never released");
            @(negedge clk);
        end
        check_bit("reset stall", 1'b0, bus_stall);
        check_bit("reset irq", 1'b0, tick_irq);
        check_word("reset gpio_out", '0, gpio_out);
        run_patterns();
        random_ram_test();
        gpio_input_test();
        ticker_test();
        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk_o,
    output logic rst_n_o
);

    localparam int HALF_PERIOD_NS = 2;
    localparam int RESET_CYCLES = 16;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
    end

    // reset is released on a rising edge like any other driven input.
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

//--- verilog/soc_bus_top.sv
`timescale 1ns/1ps

module soc_bus_top import soc_bus_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n_i,

    input  logic [BUS_WIDTH-1:0] bus_address_i,
    input  logic [BE_WIDTH-1:0]  bus_byteenable_i,
    input  logic                 bus_read_i,
    input  logic                 bus_write_i,
    input  logic [BUS_WIDTH-1:0] bus_wrdata_i,
    output logic [BUS_WIDTH-1:0] bus_rddata_o,
    output logic                 bus_stall_o,

    input  logic [BUS_WIDTH-1:0] gpio_in_i,
    output logic [BUS_WIDTH-1:0] gpio_out_o,
    output logic                 tick_irq_o
);

    logic [RAM_AW-1:0] ram_word;
    logic [BE_WIDTH-1:0] ram_byteenable;
    logic ram_read;
    logic ram_write;
    logic [BUS_WIDTH-1:0] ram_wrdata;
    logic [BUS_WIDTH-1:0] ram_rddata;
    logic ram_stall;

    logic mem_en;
    logic mem_we;
    logic [RAM_AW-1:0] mem_addr;
    logic [BUS_WIDTH-1:0] mem_wrdata;
    logic [BUS_WIDTH-1:0] mem_rddata;

    logic [REG_AW-1:0] gpio_reg;
    logic gpio_read;
    logic gpio_write;
    logic [BUS_WIDTH-1:0] gpio_rddata;

    logic [REG_AW-1:0] ticker_reg;
    logic ticker_read;
    logic ticker_write;
    logic [BUS_WIDTH-1:0] ticker_rddata;

    logic [BUS_WIDTH-1:0] io_wrdata;
    logic [BE_WIDTH-1:0] io_byteenable;

    dbus dbus_i (
        .clk                 (clk),
        .rst_n_i             (rst_n_i),
        .master_address_i    (bus_address_i),
        .master_byteenable_i (bus_byteenable_i),
        .master_read_i       (bus_read_i),
        .master_write_i      (bus_write_i),
        .master_wrdata_i     (bus_wrdata_i),
        .master_rddata_o     (bus_rddata_o),
        .master_stall_o      (bus_stall_o),
        .ram_word_o          (ram_word),
        .ram_byteenable_o    (ram_byteenable),
        .ram_read_o          (ram_read),
        .ram_write_o         (ram_write),
        .ram_wrdata_o        (ram_wrdata),
        .ram_rddata_i        (ram_rddata),
        .ram_stall_i         (ram_stall),
        .gpio_reg_o          (gpio_reg),
        .gpio_read_o         (gpio_read),
        .gpio_write_o        (gpio_write),
        .gpio_rddata_i       (gpio_rddata),
        .ticker_reg_o        (ticker_reg),
        .ticker_read_o       (ticker_read),
        .ticker_write_o      (ticker_write),
        .ticker_rddata_i     (ticker_rddata),
        .io_wrdata_o         (io_wrdata),
        .io_byteenable_o     (io_byteenable)
    );

    bytes_conv conv_i (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .word_i       (ram_word),
        .byteenable_i (ram_byteenable),
        .read_i       (ram_read),
        .write_i      (ram_write),
        .wrdata_i     (ram_wrdata),
        .rddata_o     (ram_rddata),
        .stall_o      (ram_stall),
        .mem_en_o     (mem_en),
        .mem_we_o     (mem_we),
        .mem_addr_o   (mem_addr),
        .mem_wrdata_o (mem_wrdata),
        .mem_rddata_i (mem_rddata)
    );

    data_ram ram_i (
        .clk      (clk),
        .en_i     (mem_en),
        .we_i     (mem_we),
        .addr_i   (mem_addr),
        .wrdata_i (mem_wrdata),
        .rddata_o (mem_rddata)
    );

    gpio_regs gpio_i (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .reg_i        (gpio_reg),
        .read_i       (gpio_read),
        .write_i      (gpio_write),
        .wrdata_i     (io_wrdata),
        .byteenable_i (io_byteenable),
        .rddata_o     (gpio_rddata),
        .gpio_in_i    (gpio_in_i),
        .gpio_out_o   (gpio_out_o)
    );

    ticker ticker_i (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .reg_i    (ticker_reg),
        .read_i   (ticker_read),
        .write_i  (ticker_write),
        .wrdata_i (io_wrdata),
        .rddata_o (ticker_rddata),
        .irq_o    (tick_irq_o)
    );

endmodule

//--- verilog/dbus.sv
`timescale 1ns/1ps

module dbus import soc_bus_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n_i,

    input  logic [BUS_WIDTH-1:0] master_address_i,
    input  logic [BE_WIDTH-1:0]  master_byteenable_i,
    input  logic                 master_read_i,
    input  logic                 master_write_i,
    input  logic [BUS_WIDTH-1:0] master_wrdata_i,
    output logic [BUS_WIDTH-1:0] master_rddata_o,
    output logic                 master_stall_o,

    output logic [RAM_AW-1:0]    ram_word_o,
    output logic [BE_WIDTH-1:0]  ram_byteenable_o,
    output logic                 ram_read_o,
    output logic                 ram_write_o,
    output logic [BUS_WIDTH-1:0] ram_wrdata_o,
    input  logic [BUS_WIDTH-1:0] ram_rddata_i,
    input  logic                 ram_stall_i,

    output logic [REG_AW-1:0]    gpio_reg_o,
    output logic                 gpio_read_o,
    output logic                 gpio_write_o,
    input  logic [BUS_WIDTH-1:0] gpio_rddata_i,

    output logic [REG_AW-1:0]    ticker_reg_o,
    output logic                 ticker_read_o,
    output logic                 ticker_write_o,
    input  logic [BUS_WIDTH-1:0] ticker_rddata_i,

    output logic [BUS_WIDTH-1:0] io_wrdata_o,
    output logic [BE_WIDTH-1:0]  io_byteenable_o
);

    bus_addr_t addr;
    logic req;
    logic hit_ram;
    logic hit_gpio;
    logic hit_ticker;
    logic sel_ram;
    logic ram_busy_q;

    assign addr = master_address_i;
    assign req = master_read_i | master_write_i;

    assign hit_ram = (addr.ram.region == REGION_RAM);
    assign hit_gpio = (addr.io.region == REGION_IO) && (addr.io.dev == DEV_GPIO);
    assign hit_ticker = (addr.io.region == REGION_IO) && (addr.io.dev == DEV_TICKER);

    // a stalled RAM transaction keeps the RAM selected until it completes.
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ram_busy_q <= 1'b0;
        end else begin
            ram_busy_q <= sel_ram && req && ram_stall_i;
        end
    end

    assign sel_ram = ram_busy_q | hit_ram;

    assign ram_word_o = addr.ram.word;
    assign ram_byteenable_o = master_byteenable_i;
    assign ram_wrdata_o = master_wrdata_i;
    assign ram_read_o = master_read_i & sel_ram;
    assign ram_write_o = master_write_i & sel_ram;

    // peripherals never stall, so a held request lasts one cycle.
    assign gpio_reg_o = addr.io.regnum;
    assign gpio_read_o = master_read_i & hit_gpio & ~ram_busy_q;
    assign gpio_write_o = master_write_i & hit_gpio & ~ram_busy_q;

    assign ticker_reg_o = addr.io.regnum;
    assign ticker_read_o = master_read_i & hit_ticker & ~ram_busy_q;
    assign ticker_write_o = master_write_i & hit_ticker & ~ram_busy_q;

    assign io_wrdata_o = master_wrdata_i;
    assign io_byteenable_o = master_byteenable_i;

    assign master_stall_o = sel_ram & ram_stall_i;

    always_comb begin
        if (sel_ram) begin
            master_rddata_o = ram_rddata_i;
        end else if (hit_gpio) begin
            master_rddata_o = gpio_rddata_i;
        end else if (hit_ticker) begin
            master_rddata_o = ticker_rddata_i;
        end else begin
            master_rddata_o = '0;
        end
    end

endmodule

//--- verilog/ticker.sv
`timescale 1ns/1ps

module ticker import soc_bus_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n_i,

    input  logic [REG_AW-1:0]    reg_i,
    input  logic                 read_i,
    input  logic                 write_i,
    input  logic [BUS_WIDTH-1:0] wrdata_i,
    output logic [BUS_WIDTH-1:0] rddata_o,

    output logic                 irq_o
);

    logic [BUS_WIDTH-1:0] count_q;
    logic [BUS_WIDTH-1:0] compare_q;
    logic pending_q;
    logic hit;

    // a zero compare value disables the match.
    assign hit = (count_q == compare_q) && (compare_q != '0);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            count_q <= '0;
            compare_q <= '0;
            pending_q <= 1'b0;
        end else begin
            if (write_i && reg_i == TICK_COUNT) begin
                count_q <= wrdata_i;
            end else begin
                count_q <= count_q + 1'b1;
            end
            if (write_i && reg_i == TICK_COMPARE) begin
                compare_q <= wrdata_i;
            end
            // a new match wins over a clear in the same cycle.
            if (hit) begin
                pending_q <= 1'b1;
            end else if (write_i && reg_i == TICK_STATUS && wrdata_i[0]) begin
                pending_q <= 1'b0;
            end
        end
    end

    always_comb begin
        rddata_o = '0;
        if (read_i) begin
            case (reg_i)
                TICK_COUNT:   rddata_o = count_q;
                TICK_COMPARE: rddata_o = compare_q;
                TICK_STATUS:  rddata_o = {{(BUS_WIDTH-1){1'b0}}, pending_q};
                default:      rddata_o = '0;
            endcase
        end
    end

    assign irq_o = pending_q;

endmodule

//--- verilog/gpio_regs.sv
`timescale 1ns/1ps

module gpio_regs import soc_bus_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n_i,

    input  logic [REG_AW-1:0]    reg_i,
    input  logic                 read_i,
    input  logic                 write_i,
    input  logic [BUS_WIDTH-1:0] wrdata_i,
    input  logic [BE_WIDTH-1:0]  byteenable_i,
    output logic [BUS_WIDTH-1:0] rddata_o,

    input  logic [BUS_WIDTH-1:0] gpio_in_i,
    output logic [BUS_WIDTH-1:0] gpio_out_o
);

    logic [BUS_WIDTH-1:0] out_q;
    logic [BUS_WIDTH-1:0] in_meta_q;
    logic [BUS_WIDTH-1:0] in_sync_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            out_q <= '0;
        end else if (write_i && reg_i == GPIO_OUT) begin
            out_q <= merge_bytes(out_q, wrdata_i, byteenable_i);
        end
    end

    // two-flop synchronizer for the asynchronous input pins.
    always_ff @(posedge clk) begin
        in_meta_q <= gpio_in_i;
        in_sync_q <= in_meta_q;
    end

    always_comb begin
        rddata_o = '0;
        if (read_i) begin
            case (reg_i)
                GPIO_OUT: rddata_o = out_q;
                GPIO_IN:  rddata_o = in_sync_q;
                default:  rddata_o = '0;
            endcase
        end
    end

    assign gpio_out_o = out_q;

endmodule

//--- verilog/bytes_conv.sv
`timescale 1ns/1ps

module bytes_conv import soc_bus_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n_i,

    input  logic [RAM_AW-1:0]    word_i,
    input  logic [BE_WIDTH-1:0]  byteenable_i,
    input  logic                 read_i,
    input  logic                 write_i,
    input  logic [BUS_WIDTH-1:0] wrdata_i,
    output logic [BUS_WIDTH-1:0] rddata_o,
    output logic                 stall_o,

    output logic                 mem_en_o,
    output logic                 mem_we_o,
    output logic [RAM_AW-1:0]    mem_addr_o,
    output logic [BUS_WIDTH-1:0] mem_wrdata_o,
    input  logic [BUS_WIDTH-1:0] mem_rddata_i
);

    logic [1:0] state_q;
    logic [1:0] state_d;
    logic [BUS_WIDTH-1:0] merged_q;
    logic full_word;

    assign full_word = &byteenable_i;
    assign mem_addr_o = word_i;
    assign rddata_o = mem_rddata_i;

    always_comb begin
        state_d = state_q;
        mem_en_o = 1'b0;
        mem_we_o = 1'b0;
        mem_wrdata_o = wrdata_i;
        stall_o = 1'b0;
        case (state_q)
            CONV_IDLE: begin
                mem_en_o = read_i | write_i;
                mem_we_o = write_i & full_word;
                if (read_i) begin
                    stall_o = 1'b1;
                    state_d = CONV_READ_WAIT;
                end else if (write_i && !full_word) begin
                    // the old word is fetched first and merged next cycle.
                    stall_o = 1'b1;
                    state_d = CONV_MERGE;
                end
            end
            CONV_READ_WAIT: begin
                state_d = CONV_IDLE;
            end
            CONV_MERGE: begin
                stall_o = 1'b1;
                state_d = CONV_WRITE;
            end
            CONV_WRITE: begin
                mem_en_o = 1'b1;
                mem_we_o = 1'b1;
                mem_wrdata_o = merged_q;
                state_d = CONV_IDLE;
            end
            default: begin
                state_d = CONV_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= CONV_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == CONV_MERGE) begin
            merged_q <= merge_bytes(mem_rddata_i, wrdata_i, byteenable_i);
        end
    end

endmodule

//--- verilog/data_ram.sv
`timescale 1ns/1ps

module data_ram import soc_bus_pkg::*; (
    input  logic                 clk,
    input  logic                 en_i,
    input  logic                 we_i,
    input  logic [RAM_AW-1:0]    addr_i,
    input  logic [BUS_WIDTH-1:0] wrdata_i,
    output logic [BUS_WIDTH-1:0] rddata_o
);

    logic [BUS_WIDTH-1:0] mem [RAM_WORDS];

    // read data holds its value until the next read.
    always_ff @(posedge clk) begin
        if (en_i) begin
            if (we_i) begin
                mem[addr_i] <= wrdata_i;
            end else begin
                rddata_o <= mem[addr_i];
            end
        end
    end

endmodule

//--- verilog/soc_bus_pkg.sv
package soc_bus_pkg;

    localparam int BUS_WIDTH = 32;
    localparam int BE_WIDTH = BUS_WIDTH / 8;
    localparam int RAM_WORDS = 256;
    localparam int RAM_AW = $clog2(RAM_WORDS);
    localparam int REG_AW = 6;

    // top four address bits select the region.
    localparam logic [3:0] REGION_RAM = 4'h0;
    localparam logic [3:0] REGION_IO = 4'hB;

    localparam logic [7:0] DEV_GPIO = 8'h00;
    localparam logic [7:0] DEV_TICKER = 8'h01;

    localparam logic [REG_AW-1:0] GPIO_OUT = 6'd0;
    localparam logic [REG_AW-1:0] GPIO_IN = 6'd1;
    localparam logic [REG_AW-1:0] TICK_COUNT = 6'd0;
    localparam logic [REG_AW-1:0] TICK_COMPARE = 6'd1;
    localparam logic [REG_AW-1:0] TICK_STATUS = 6'd2;

    localparam logic [1:0] CONV_IDLE = 2'd0;
    localparam logic [1:0] CONV_READ_WAIT = 2'd1;
    localparam logic [1:0] CONV_MERGE = 2'd2;
    localparam logic [1:0] CONV_WRITE = 2'd3;

    typedef struct packed {
        logic [3:0] region;
        logic [BUS_WIDTH-7-RAM_AW:0] unused;
        logic [RAM_AW-1:0] word;
        logic [1:0] offset;
    } ram_addr_t;

    typedef struct packed {
        logic [3:0] region;
        logic [BUS_WIDTH-15-REG_AW:0] unused;
        logic [7:0] dev;
        logic [REG_AW-1:0] regnum;
        logic [1:0] offset;
    } io_addr_t;

    typedef union packed {
        ram_addr_t ram;
        io_addr_t io;
    } bus_addr_t;

    // replaces the enabled bytes of old_word with those of new_word.
    function automatic logic [BUS_WIDTH-1:0] merge_bytes(
        input logic [BUS_WIDTH-1:0] old_word,
        input logic [BUS_WIDTH-1:0] new_word,
        input logic [BE_WIDTH-1:0] be
    );
        logic [BUS_WIDTH-1:0] result;
        result = old_word;
        for (int i = 0; i < BE_WIDTH; i++) begin
            if (be[i]) begin
                result[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return result;
    endfunction

endpackage
